// File: Bender.yml
package:
  name: sniffer_ctrl

sources:
  - files:
      - logic/sniffer_ctrl_pkg.sv
      - logic/spi_pin_sync.sv
      - logic/spi_shifter.sv
      - logic/frame_ctrl.sv
      - logic/reg_bank.sv
      - logic/link_status.sv
      - logic/sniffer_ctrl_top.sv
  - target: test
    files:
      - verif/sniffer_ctrl_sva.sv
      - verif/sniffer_ctrl_tb.sv

// File: logic/frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl #(
    parameter int ADDR_BITS = 6
) (
    input  logic                                    clk_ctrl,
    input  logic                                    main_rst,
    input  sniffer_ctrl_pkg::spi_events_t           events,
    input  sniffer_ctrl_pkg::frame_byte_u           rx_byte,
    input  logic                                    byte_done,
    input  logic [sniffer_ctrl_pkg::BYTE_W-1:0]     rd_data,
    input  sniffer_ctrl_pkg::status_t               status,
    output sniffer_ctrl_pkg::frame_byte_u           tx_byte,
    output sniffer_ctrl_pkg::bank_wr_t              bank_wr,
    output logic [sniffer_ctrl_pkg::HDR_ADDR_W-1:0] rd_addr,
    output sniffer_ctrl_pkg::frame_result_t         result
);
    import sniffer_ctrl_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        INFO,
        DATA,
        DONE,
        FAULT
    } state_e;

    state_e            state_q;
    err_code_e         err_q;     // Reason for FAULT
    err_code_e         end_code;
    err_code_e         code_q;
    logic              read_q;    // Latched mode bits
    logic              fmt_q;
    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  count_q;   // Data bytes done
    logic [LEN_W-1:0]  count_next;
    logic              last_byte;
    logic [ADDR_BITS-1:0] addr_q; // Running address, wraps with bank size
    logic              wr_en_q;
    logic [HDR_ADDR_W-1:0] wr_addr_q;
    logic [BYTE_W-1:0] wr_data_q;
    logic              done_q;

    assign count_next = count_q + 1'b1;
    assign last_byte  = fmt_q ? (count_next == len_q) : 1'b1; // Single write has one byte
    assign rd_addr    = HDR_ADDR_W'(addr_q);
    assign bank_wr    = '{en: wr_en_q, addr: wr_addr_q, data: wr_data_q};
    assign result     = '{done: done_q, code: code_q};

    // Reply for the next byte, sampled on frame_start or byte_done
    always_comb begin
        tx_byte = rx_byte; // Echo by default
        case (state_q)
            IDLE: tx_byte = frame_byte_u'(status);
            INFO: if (read_q && rx_byte.info.len != '0) tx_byte = rd_data;
            DATA: if (read_q && !last_byte) tx_byte = rd_data;
            default: tx_byte = rx_byte;
        endcase
    end

    always_comb begin
        case (state_q)
            DONE:    end_code = ERR_NONE;
            FAULT:   end_code = err_q;
            default: end_code = ERR_EARLY_END; // SS rose mid frame
        endcase
    end

    always_ff @(posedge clk_ctrl) begin
        if (main_rst) begin
            state_q <= IDLE;
            err_q   <= ERR_NONE;
            read_q  <= 1'b0;
            fmt_q   <= 1'b0;
            len_q   <= '0;
            count_q <= '0;
            wr_en_q <= 1'b0;
            done_q  <= 1'b0;
            code_q  <= ERR_NONE;
        end else begin
            wr_en_q <= 1'b0;
            done_q  <= 1'b0;
            if (events.frame_end) begin
                state_q <= IDLE; // Recovery ends here
                if (state_q != IDLE) begin
                    done_q <= 1'b1;
                    code_q <= end_code;
                end
            end else if (state_q == IDLE) begin
                if (events.frame_start) begin
                    state_q <= HEADER;
                    err_q   <= ERR_NONE;
                end
            end else if (byte_done) begin
                case (state_q)
                    HEADER: begin
                        read_q  <= rx_byte.hdr.read;
                        fmt_q   <= rx_byte.hdr.format;
                        count_q <= '0;
                        if (rx_byte.hdr.read && !rx_byte.hdr.format) begin
                            state_q <= FAULT;
                            err_q   <= ERR_BAD_HEADER;
                        end else if (rx_byte.hdr.format) begin
                            state_q <= INFO;
                        end else begin
                            state_q <= DATA; // Single write
                        end
                    end
                    INFO: begin
                        len_q   <= rx_byte.info.len; // Upper bits ignored
                        state_q <= (rx_byte.info.len == '0) ? DONE : DATA;
                    end
                    DATA: begin
                        wr_en_q <= !read_q;
                        count_q <= count_next;
                        if (last_byte) state_q <= DONE;
                    end
                    DONE: begin
                        state_q <= FAULT;
                        err_q   <= ERR_OVERRUN;
                    end
                    FAULT: state_q <= FAULT;
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    // Address and write payload
    always_ff @(posedge clk_ctrl) begin
        if (byte_done) begin
            case (state_q)
                HEADER: addr_q <= rx_byte.hdr.addr[ADDR_BITS-1:0];
                INFO:   if (read_q) addr_q <= addr_q + 1'b1; // Byte 0 already read
                DATA: begin
                    wr_addr_q <= rd_addr;
                    wr_data_q <= rx_byte;
                    addr_q    <= addr_q + 1'b1;
                end
                default: addr_q <= addr_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/link_status.sv
`timescale 1ns/1ps
`default_nettype none

module link_status (
    input  logic                            clk_ctrl,
    input  logic                            main_rst,
    input  sniffer_ctrl_pkg::frame_result_t result,
    output sniffer_ctrl_pkg::status_t       status
);
    import sniffer_ctrl_pkg::*;

    status_t status_q;

    // Every finished frame counts, errored ones too
    always_ff @(posedge clk_ctrl) begin
        if (main_rst) begin
            status_q.frame_count <= '0;
            status_q.code        <= ERR_NONE;
        end else if (result.done) begin
            status_q.frame_count <= status_q.frame_count + 1'b1; // Wraps at 64
            status_q.code        <= result.code;
        end
    end

    assign status = status_q; // Valid the cycle after done

endmodule

`default_nettype wire

// File: logic/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank #(
    parameter int ADDR_BITS = 6
) (
    input  logic                                    clk_ctrl,
    input  logic                                    main_rst,
    input  sniffer_ctrl_pkg::bank_wr_t              bank_wr,
    input  logic [sniffer_ctrl_pkg::HDR_ADDR_W-1:0] rd_addr,
    output logic [sniffer_ctrl_pkg::BYTE_W-1:0]     rd_data
);
    import sniffer_ctrl_pkg::*;

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [BYTE_W-1:0] mem [DEPTH];

    // Cleared on reset, one write per cycle
    always_ff @(posedge clk_ctrl) begin
        if (main_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (bank_wr.en) begin
            mem[bank_wr.addr[ADDR_BITS-1:0]] <= bank_wr.data; // Low bits only
        end
    end

    assign rd_data = mem[rd_addr[ADDR_BITS-1:0]]; // Same cycle read

endmodule

`default_nettype wire

// File: logic/sniffer_ctrl_pkg.sv
`default_nettype none

package sniffer_ctrl_pkg;

    localparam int BYTE_W     = 8; // Bits per SPI byte
    localparam int HDR_ADDR_W = 6; // Header address field
    localparam int LEN_W      = 5; // Info length field

    // First byte of every frame
    typedef struct packed {
        logic                  read;   // Burst read when set with format
        logic                  format; // Burst framing with info byte
        logic [HDR_ADDR_W-1:0] addr;   // Start address
    } header_t;

    // Second byte of a burst frame
    typedef struct packed {
        logic [BYTE_W-LEN_W-1:0] extra; // Reserved, ignored
        logic [LEN_W-1:0]        len;   // Data bytes that follow
    } info_t;

    // Same received byte, decoded by its frame position
    typedef union packed {
        header_t hdr;
        info_t   info;
    } frame_byte_u;

    typedef enum logic [1:0] {
        ERR_NONE       = 2'd0,
        ERR_BAD_HEADER = 2'd1, // Read without format
        ERR_EARLY_END  = 2'd2, // SS high before last byte
        ERR_OVERRUN    = 2'd3  // Bytes after frame completion
    } err_code_e;

    // Synchronized pin events, one-cycle strobes except mosi
    typedef struct packed {
        logic sck_rise;
        logic sck_fall;
        logic mosi;        // Level, aligned with sck_rise
        logic frame_start; // SS falling
        logic frame_end;   // SS rising
    } spi_events_t;

    typedef struct packed {
        logic                  en;
        logic [HDR_ADDR_W-1:0] addr;
        logic [BYTE_W-1:0]     data;
    } bank_wr_t;

    typedef struct packed {
        logic      done; // Strobe at frame end
        err_code_e code;
    } frame_result_t;

    // Byte returned during every header
    typedef struct packed {
        logic [5:0] frame_count; // Wrapping
        err_code_e  code;        // Result of last frame
    } status_t;

endpackage

`default_nettype wire

// File: logic/sniffer_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module sniffer_ctrl_top #(
    parameter int ADDR_BITS   = 6, // 1 to 6
    parameter int SYNC_STAGES = 2  // 2 or more
) (
    input  logic clk_ctrl,
    input  logic main_rst,
    input  logic spi_sck,
    input  logic spi_ss,
    input  logic spi_mosi,
    output logic spi_miso
);
    import sniffer_ctrl_pkg::*;

    spi_events_t           events;
    frame_byte_u           rx_byte;
    frame_byte_u           tx_byte;
    logic                  byte_done;
    bank_wr_t              bank_wr;
    logic [HDR_ADDR_W-1:0] rd_addr;
    logic [BYTE_W-1:0]     rd_data;
    frame_result_t         result;
    status_t               status;

    spi_pin_sync #(
        .SYNC_STAGES(SYNC_STAGES)
    ) u_pin_sync (
        .clk_ctrl(clk_ctrl),
        .main_rst(main_rst),
        .spi_sck (spi_sck),
        .spi_ss  (spi_ss),
        .spi_mosi(spi_mosi),
        .events  (events)
    );

    spi_shifter u_shifter (
        .clk_ctrl (clk_ctrl),
        .main_rst (main_rst),
        .events   (events),
        .tx_byte  (tx_byte),
        .rx_byte  (rx_byte),
        .byte_done(byte_done),
        .spi_miso (spi_miso)
    );

    // Frame decode and reply select
    frame_ctrl #(
        .ADDR_BITS(ADDR_BITS)
    ) u_frame_ctrl (
        .clk_ctrl (clk_ctrl),
        .main_rst (main_rst),
        .events   (events),
        .rx_byte  (rx_byte),
        .byte_done(byte_done),
        .rd_data  (rd_data),
        .status   (status),
        .tx_byte  (tx_byte),
        .bank_wr  (bank_wr),
        .rd_addr  (rd_addr),
        .result   (result)
    );

    reg_bank #(
        .ADDR_BITS(ADDR_BITS)
    ) u_reg_bank (
        .clk_ctrl(clk_ctrl),
        .main_rst(main_rst),
        .bank_wr (bank_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    link_status u_link_status (
        .clk_ctrl(clk_ctrl),
        .main_rst(main_rst),
        .result  (result),
        .status  (status)   // Back to frame_ctrl for header reply
    );

endmodule

`default_nettype wire

// File: logic/spi_pin_sync.sv
`timescale 1ns/1ps
`default_nettype none

module spi_pin_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                          clk_ctrl,
    input  logic                          main_rst,
    input  logic                          spi_sck,
    input  logic                          spi_ss,
    input  logic                          spi_mosi,
    output sniffer_ctrl_pkg::spi_events_t events
);
    import sniffer_ctrl_pkg::*;

    logic [SYNC_STAGES-1:0] sck_sync;
    logic [SYNC_STAGES-1:0] ss_sync;
    logic [SYNC_STAGES-1:0] mosi_sync;
    logic                   sck_hist; // Previous synchronized SCK
    logic                   ss_hist;  // Previous synchronized SS
    logic                   sck_s;
    logic                   ss_s;

    assign sck_s = sck_sync[SYNC_STAGES-1];
    assign ss_s  = ss_sync[SYNC_STAGES-1];

    // Control chains, SS idles high so no false edge leaving reset
    always_ff @(posedge clk_ctrl) begin
        if (main_rst) begin
            sck_sync <= '0;
            ss_sync  <= '1;
            sck_hist <= 1'b0;
            ss_hist  <= 1'b1;
        end else begin
            sck_sync <= {sck_sync[SYNC_STAGES-2:0], spi_sck};
            ss_sync  <= {ss_sync[SYNC_STAGES-2:0], spi_ss};
            sck_hist <= sck_s;
            ss_hist  <= ss_s;
        end
    end

    always_ff @(posedge clk_ctrl) begin
        mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi}; // Same depth as SCK
    end

    // Registered strobes, SYNC_STAGES+1 cycles after the pin
    always_ff @(posedge clk_ctrl) begin
        if (main_rst) begin
            events <= '0;
        end else begin
            events.sck_rise    <= sck_s & ~sck_hist & ~ss_s; // Only inside a frame
            events.sck_fall    <= ~sck_s & sck_hist & ~ss_s;
            events.mosi        <= mosi_sync[SYNC_STAGES-1];
            events.frame_start <= ~ss_s & ss_hist;
            events.frame_end   <= ss_s & ~ss_hist;
        end
    end

endmodule

`default_nettype wire

// File: logic/spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shifter (
    input  logic                          clk_ctrl,
    input  logic                          main_rst,
    input  sniffer_ctrl_pkg::spi_events_t events,
    input  sniffer_ctrl_pkg::frame_byte_u tx_byte,
    output sniffer_ctrl_pkg::frame_byte_u rx_byte,
    output logic                          byte_done,
    output logic                          spi_miso
);
    import sniffer_ctrl_pkg::*;

    localparam int CNT_W = $clog2(BYTE_W);

    logic [CNT_W-1:0]  bit_cnt;  // Bits of the current byte
    logic [BYTE_W-1:0] rx_sr;
    logic [BYTE_W-1:0] tx_sr;
    logic              last_bit;

    assign last_bit = (bit_cnt == CNT_W'(BYTE_W - 1));
    assign rx_byte  = rx_sr;             // Complete while byte_done is high
    assign spi_miso = tx_sr[BYTE_W-1];   // MSB first

    // Bit count and byte strobe
    always_ff @(posedge clk_ctrl) begin
        if (main_rst) begin
            bit_cnt   <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= events.sck_rise & last_bit; // One cycle after eighth rise
            if (events.frame_start || events.frame_end) begin
                bit_cnt <= '0; // Partial byte dropped
            end else if (events.sck_rise) begin
                bit_cnt <= bit_cnt + 1'b1; // Wraps per byte
            end
        end
    end

    always_ff @(posedge clk_ctrl) begin
        if (events.sck_rise) begin
            rx_sr <= {rx_sr[BYTE_W-2:0], events.mosi};
        end
    end

    // Reply register
    always_ff @(posedge clk_ctrl) begin
        if (main_rst) begin
            tx_sr <= '0;
        end else if (events.frame_end) begin
            tx_sr <= '0; // MISO low between frames
        end else if (events.frame_start || byte_done) begin
            tx_sr <= tx_byte;
        end else if (events.sck_fall && bit_cnt != '0) begin
            // Fall after the eighth rise keeps the new MSB
            tx_sr <= {tx_sr[BYTE_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// File: sniffer_ctrl.f
logic/sniffer_ctrl_pkg.sv
logic/spi_pin_sync.sv
logic/spi_shifter.sv
logic/frame_ctrl.sv
logic/reg_bank.sv
logic/link_status.sv
logic/sniffer_ctrl_top.sv
verif/sniffer_ctrl_sva.sv
verif/sniffer_ctrl_tb.sv

// File: verif/sniffer_ctrl_sva.sv
`timescale 1ns/1ps
`default_nettype none

module sniffer_ctrl_sva (
    input logic                            clk_ctrl,
    input logic                            main_rst,
    input sniffer_ctrl_pkg::spi_events_t   events,
    input logic                            byte_done,
    input sniffer_ctrl_pkg::bank_wr_t      bank_wr,
    input sniffer_ctrl_pkg::frame_result_t result,
    input logic [2:0]                      state_q
);
    localparam logic [2:0] ST_IDLE  = 3'd0; // Encodings of frame_ctrl states
    localparam logic [2:0] ST_DONE  = 3'd4;
    localparam logic [2:0] ST_FAULT = 3'd5;

    int   fail_count;
    logic in_frame; // SS low as seen after the synchronizer

    initial fail_count = 0;

    always_ff @(posedge clk_ctrl) begin
        if (main_rst) begin
            in_frame <= 1'b0;
        end else if (events.frame_start) begin
            in_frame <= 1'b1;
        end else if (events.frame_end) begin
            in_frame <= 1'b0;
        end
    end

    write_in_frame: assert property (@(posedge clk_ctrl) disable iff (main_rst)
        bank_wr.en |-> in_frame)
    else begin
        fail_count++;
        $error("bank write while SS is high");
    end

    // Eight SCK rises per byte keep strobes far apart
    byte_spacing: assert property (@(posedge clk_ctrl) disable iff (main_rst)
        byte_done |=> !byte_done [*7])
    else begin
        fail_count++;
        $error("byte_done strobes closer than 8 cycles");
    end

    end_to_idle: assert property (@(posedge clk_ctrl) disable iff (main_rst)
        events.frame_end && (state_q == ST_DONE || state_q == ST_FAULT) |=> state_q == ST_IDLE)
    else begin
        fail_count++;
        $error("frame_ctrl did not return to IDLE on frame end");
    end

    done_pulse: assert property (@(posedge clk_ctrl) disable iff (main_rst)
        result.done |=> !result.done)
    else begin
        fail_count++;
        $error("result.done longer than one cycle");
    end

endmodule

bind frame_ctrl sniffer_ctrl_sva u_sva (
    .clk_ctrl (clk_ctrl),
    .main_rst (main_rst),
    .events   (events),
    .byte_done(byte_done),
    .bank_wr  (bank_wr),
    .result   (result),
    .state_q  (state_q)
);

`default_nettype wire

// File: verif/sniffer_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sniffer_ctrl_tb;
    import sniffer_ctrl_pkg::*;

    localparam int HALF_SCK     = 8;   // clk_ctrl cycles per SCK phase
    localparam int IDLE_CYCLES  = 20;  // Gap between frames
    localparam int DONE_TIMEOUT = 100; // Cycles allowed for frame result

    logic clk_ctrl;
    logic main_rst;
    logic spi_sck;
    logic spi_ss;
    logic spi_mosi;
    logic spi_miso;

    logic [31:0] rng_state;
    logic [7:0]  model_mem [64];  // Reference bank
    logic [5:0]  model_count;
    err_code_e   model_code;
    logic [7:0]  tx_buf [40];     // Bytes of the next frame
    int          checks;
    int          mismatches;
    int          timeouts;

    sniffer_ctrl_top #(
        .ADDR_BITS  (6),
        .SYNC_STAGES(2)
    ) dut (
        .clk_ctrl(clk_ctrl),
        .main_rst(main_rst),
        .spi_sck (spi_sck),
        .spi_ss  (spi_ss),
        .spi_mosi(spi_mosi),
        .spi_miso(spi_miso)
    );

    always #5 clk_ctrl = ~clk_ctrl;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        rng_state = x;
        return x;
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge clk_ctrl);
    endtask

    // Mode 0 byte with MISO sampled just before each rise
    task automatic shift_byte(input logic [7:0] out_byte, output logic [7:0] in_byte);
        for (int b = 7; b >= 0; b--) begin
            spi_mosi = out_byte[b];
            idle(HALF_SCK);
            in_byte[b] = spi_miso;
            spi_sck = 1'b1;
            idle(HALF_SCK);
            spi_sck = 1'b0;
        end
    endtask

    task automatic wait_frame_done();
        int cnt;
        cnt = 0;
        while (dut.result.done !== 1'b1 && cnt < DONE_TIMEOUT) begin
            @(negedge clk_ctrl);
            cnt++;
        end
        assert (dut.result.done === 1'b1) else begin
            timeouts++;
            $display("timeout at %0t: no frame result after SS went high", $time);
        end
    endtask

    // One frame of n bytes from tx_buf with replies checked byte by byte
    task automatic run_frame(input int n, input bit burst_rd, input logic [5:0] addr,
                             input err_code_e code);
        logic [7:0] rx;
        logic [7:0] exp;
        spi_ss = 1'b0;
        idle(HALF_SCK);
        for (int k = 0; k < n; k++) begin
            if (k == 0) begin
                exp = {model_count, model_code}; // Status of previous frame
            end else if (burst_rd && k >= 2) begin
                exp = model_mem[6'(addr + k - 2)];
            end else begin
                exp = tx_buf[k-1]; // Echo
            end
            shift_byte(tx_buf[k], rx);
            checks++;
            assert (rx == exp) else begin
                mismatches++;
                $display("mismatch at %0t: reply byte %0d got %h expected %h",
                         $time, k, rx, exp);
            end
        end
        idle(HALF_SCK);
        spi_ss = 1'b1;
        wait_frame_done();
        model_count = model_count + 1'b1; // Wraps at 64
        model_code  = code;
        idle(IDLE_CYCLES);
        checks++;
        assert (spi_miso == 1'b0) else begin
            mismatches++;
            $display("mismatch at %0t: MISO is %b between frames", $time, spi_miso);
        end
    endtask

    task automatic single_write(input logic [5:0] addr, input logic [7:0] data,
                                input int extra);
        err_code_e code;
        tx_buf[0] = {2'b00, addr};
        tx_buf[1] = data;
        for (int i = 0; i < extra; i++) begin
            tx_buf[2+i] = 8'(next_rand()); // Overrun bytes
        end
        if (extra > 0) code = ERR_OVERRUN;
        else code = ERR_NONE;
        run_frame(2 + extra, 1'b0, addr, code);
        model_mem[addr] = data;
    endtask

    // sent below len ends the frame early
    task automatic burst_write(input logic [5:0] addr, input int len, input int sent);
        err_code_e code;
        tx_buf[0] = {2'b01, addr};
        tx_buf[1] = {3'(next_rand()), 5'(len)};
        for (int i = 0; i < sent; i++) begin
            tx_buf[2+i] = 8'(next_rand());
        end
        if (sent < len) code = ERR_EARLY_END;
        else code = ERR_NONE;
        run_frame(2 + sent, 1'b0, addr, code);
        for (int i = 0; i < sent; i++) begin
            model_mem[6'(addr + i)] = tx_buf[2+i];
        end
    endtask

    task automatic burst_read(input logic [5:0] addr, input int len);
        tx_buf[0] = {2'b11, addr};
        tx_buf[1] = {3'(next_rand()), 5'(len)}; // Upper bits ignored
        for (int i = 0; i < len; i++) begin
            tx_buf[2+i] = 8'(next_rand());
        end
        run_frame(2 + len, 1'b1, addr, ERR_NONE);
    endtask

    task automatic bad_header(input logic [5:0] addr, input int extra);
        tx_buf[0] = {2'b10, addr}; // Read without format
        for (int i = 0; i < extra; i++) begin
            tx_buf[1+i] = 8'(next_rand());
        end
        run_frame(1 + extra, 1'b0, addr, ERR_BAD_HEADER);
    endtask

    initial begin
        logic [5:0] addr;
        int         len;
        clk_ctrl    = 1'b0;
        main_rst    = 1'b1;
        spi_sck     = 1'b0;
        spi_ss      = 1'b1;
        spi_mosi    = 1'b0;
        rng_state   = 32'd60;
        checks      = 0;
        mismatches  = 0;
        timeouts    = 0;
        model_count = '0;
        model_code  = ERR_NONE;
        for (int i = 0; i < 64; i++) begin
            model_mem[i] = 8'h00;
        end
        repeat (4) @(negedge clk_ctrl);
        main_rst = 1'b0;
        idle(IDLE_CYCLES);
        checks++;
        assert (spi_miso == 1'b0) else begin
            mismatches++;
            $display("mismatch at %0t: MISO is %b after reset", $time, spi_miso);
        end
        repeat (12) begin // Single writes
            addr = 6'(next_rand());
            single_write(addr, 8'(next_rand()), 0);
            burst_read(addr, 1 + int'(next_rand() % 4));
        end
        burst_write(6'd58, 20, 20); // Wraps past 63
        burst_read(6'd58, 20);
        burst_write(6'd63, 31, 31);
        burst_read(6'd63, 31);
        burst_write(6'd40, 0, 0); // Info byte alone completes the frame
        burst_read(6'd40, 2);
        repeat (8) begin
            addr = 6'(next_rand());
            len  = int'(5'(next_rand()));
            burst_write(addr, len, len);
            burst_read(addr, len);
        end
        repeat (3) begin // Bank must stay untouched
            addr = 6'(next_rand());
            bad_header(addr, 2);
            burst_read(addr, 4);
        end
        repeat (4) begin // SS high mid burst
            addr = 6'(next_rand());
            len  = 2 + int'(next_rand() % 30);
            burst_write(addr, len, int'(next_rand() % len));
            burst_read(addr, len);
        end
        repeat (3) begin // Extra bytes after single write
            addr = 6'(next_rand());
            single_write(addr, 8'(next_rand()), 1 + int'(next_rand() % 3));
            burst_read(addr, 4);
        end
        burst_read(6'd0, 0); // Picks up status of last frame
        $display("checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 checks, mismatches, timeouts, dut.u_frame_ctrl.u_sva.fail_count);
        if (mismatches == 0 && timeouts == 0 && dut.u_frame_ctrl.u_sva.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
